/* source/rv_timer_consts.svh */
`ifndef RV_TIMER_CONSTS_SVH
`define RV_TIMER_CONSTS_SVH

// bus data width in bits
`define RVT_XLEN 32

// byte address width of the slave port, four 32-bit registers
`define RVT_AXIL_AW 4

// system clock period in ns, must divide 1000
`define RVT_DEFAULT_CLK_PERIOD_NS 100

`endif

/* source/rv_timer_pkg.sv */
`default_nettype none

`include "rv_timer_consts.svh"

package rv_timer_pkg;

    typedef logic [`RVT_XLEN-1:0] word_t;   // one bus word

    // halves as seen from the bus
    typedef struct packed {
        word_t hi;
        word_t lo;
    } timer_half_t;

    // 64-bit timer register, counted whole but accessed in halves
    typedef union packed {
        logic [2*`RVT_XLEN-1:0] full;
        timer_half_t            half;
    } timer_reg_u;

endpackage

`default_nettype wire

/* source/axil_to_regbus.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_timer_consts.svh"

module axil_to_regbus (
    input  logic                      clk,
    input  logic                      rst_n,

    // write address channel
    input  logic [`RVT_AXIL_AW-1:0]   s_axil_awaddr,
    input  logic                      s_axil_awvalid,
    output logic                      s_axil_awready,

    // write data channel
    input  rv_timer_pkg::word_t       s_axil_wdata,
    input  logic [`RVT_XLEN/8-1:0]    s_axil_wstrb,
    input  logic                      s_axil_wvalid,
    output logic                      s_axil_wready,

    // write response channel
    output logic [1:0]                s_axil_bresp,
    output logic                      s_axil_bvalid,
    input  logic                      s_axil_bready,

    // read address channel
    input  logic [`RVT_AXIL_AW-1:0]   s_axil_araddr,
    input  logic                      s_axil_arvalid,
    output logic                      s_axil_arready,

    // read data channel
    output rv_timer_pkg::word_t       s_axil_rdata,
    output logic [1:0]                s_axil_rresp,
    output logic                      s_axil_rvalid,
    input  logic                      s_axil_rready,

    // register bus
    output logic                      reg_rd_en,
    output logic                      reg_wr_en,
    output logic [1:0]                reg_addr,
    output rv_timer_pkg::word_t       reg_wr_data,
    output logic [`RVT_XLEN/8-1:0]    reg_wr_strb,
    input  rv_timer_pkg::word_t       reg_rd_data
);

    import rv_timer_pkg::*;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic  wr_hs;   // aw and w accepted together
    logic  rd_hs;
    logic  busy;    // an access is somewhere in flight
    word_t rd_word;

    assign wr_hs = s_axil_awvalid && s_axil_awready && s_axil_wvalid && s_axil_wready;
    assign rd_hs = s_axil_arvalid && s_axil_arready;

    assign busy = s_axil_awready || s_axil_arready || reg_wr_en || reg_rd_en
                  || s_axil_bvalid || s_axil_rvalid;

    assign s_axil_bresp = RESP_OKAY;   // no error responses
    assign s_axil_rresp = RESP_OKAY;
    assign s_axil_rdata = rd_word;

    // ready pulses, one cycle each, write first
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
            s_axil_arready <= 1'b0;
        end else begin
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
            s_axil_arready <= 1'b0;
            if (!busy) begin
                if (s_axil_awvalid && s_axil_wvalid) begin
                    s_axil_awready <= 1'b1;
                    s_axil_wready  <= 1'b1;
                end else if (s_axil_arvalid) begin
                    s_axil_arready <= 1'b1;
                end
            end
        end
    end

    // register strobes and response valids
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_wr_en     <= 1'b0;
            reg_rd_en     <= 1'b0;
            s_axil_bvalid <= 1'b0;
            s_axil_rvalid <= 1'b0;
        end else begin
            reg_wr_en <= wr_hs;
            reg_rd_en <= rd_hs;

            if (s_axil_bvalid && s_axil_bready)
                s_axil_bvalid <= 1'b0;
            if (wr_hs)
                s_axil_bvalid <= 1'b1;   // together with the register write

            if (s_axil_rvalid && s_axil_rready)
                s_axil_rvalid <= 1'b0;
            if (reg_rd_en)
                s_axil_rvalid <= 1'b1;   // data captured this edge
        end
    end

    // payload, shared address for both directions
    always_ff @(posedge clk) begin
        if (wr_hs) begin
            reg_addr    <= s_axil_awaddr[`RVT_AXIL_AW-1 -: 2];
            reg_wr_data <= s_axil_wdata;
            reg_wr_strb <= s_axil_wstrb;
        end else if (rd_hs) begin
            reg_addr <= s_axil_araddr[`RVT_AXIL_AW-1 -: 2];
        end

        if (reg_rd_en)
            rd_word <= reg_rd_data;
    end

endmodule

`default_nettype wire

/* source/us_prescaler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_timer_consts.svh"

module us_prescaler #(
    parameter int CLK_PERIOD_NS = `RVT_DEFAULT_CLK_PERIOD_NS   // ns per clock
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam int CYCLES_PER_TICK = 1000 / CLK_PERIOD_NS;     // clocks in one us
    localparam int CNT_W           = $clog2(CYCLES_PER_TICK + 1);

    logic [CNT_W-1:0] cnt;

    // last cycle of each microsecond
    assign tick = (cnt == CNT_W'(CYCLES_PER_TICK - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (tick) begin
            cnt <= '0;   // wrap
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/mtimer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_timer_consts.svh"

module mtimer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    tick,         // one per microsecond
    input  logic                    rd_en,
    input  logic                    wr_en,
    input  logic [1:0]              addr,         // word index
    input  rv_timer_pkg::word_t     wr_data,
    input  logic [`RVT_XLEN/8-1:0]  wr_strb,
    output rv_timer_pkg::word_t     rd_data,
    output logic [63:0]             time_value,   // time CSR view
    output logic                    irq
);

    import rv_timer_pkg::*;

    localparam logic [1:0] ADDR_MTIME_LO    = 2'd0;
    localparam logic [1:0] ADDR_MTIME_HI    = 2'd1;
    localparam logic [1:0] ADDR_MTIMECMP_LO = 2'd2;
    localparam logic [1:0] ADDR_MTIMECMP_HI = 2'd3;

    timer_reg_u mtime;
    timer_reg_u mtimecmp;
    word_t      wr_word;      // strobe-masked write data
    logic       mtime_wr;

    // disabled bytes are written as zero
    always_comb begin
        for (int b = 0; b < `RVT_XLEN/8; b++) begin
            wr_word[8*b +: 8] = wr_strb[b] ? wr_data[8*b +: 8] : 8'h00;
        end
    end

    assign mtime_wr = wr_en && (addr == ADDR_MTIME_LO || addr == ADDR_MTIME_HI);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime.full    <= '0;
            mtimecmp.full <= '0;
        end else begin
            if (tick && !mtime_wr)
                mtime.full <= mtime.full + 64'd1;

            if (wr_en) begin
                case (addr)
                    ADDR_MTIME_LO:    mtime.half.lo    <= wr_word;
                    ADDR_MTIME_HI:    mtime.half.hi    <= wr_word;
                    ADDR_MTIMECMP_LO: mtimecmp.half.lo <= wr_word;
                    ADDR_MTIMECMP_HI: mtimecmp.half.hi <= wr_word;
                    default:          ;
                endcase
            end
        end
    end

    // read mux, zero when not selected
    always_comb begin
        rd_data = '0;
        if (rd_en) begin
            case (addr)
                ADDR_MTIME_LO:    rd_data = mtime.half.lo;
                ADDR_MTIME_HI:    rd_data = mtime.half.hi;
                ADDR_MTIMECMP_LO: rd_data = mtimecmp.half.lo;
                ADDR_MTIMECMP_HI: rd_data = mtimecmp.half.hi;
                default:          rd_data = '0;
            endcase
        end
    end

    assign time_value = mtime.full;
    assign irq        = (mtime.full >= mtimecmp.full);   // unsigned compare

endmodule

`default_nettype wire

/* source/rv_timer_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_timer_consts.svh"

module rv_timer_top #(
    parameter int CLK_PERIOD_NS = `RVT_DEFAULT_CLK_PERIOD_NS
) (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic [`RVT_AXIL_AW-1:0]   s_axil_awaddr,
    input  logic                      s_axil_awvalid,
    output logic                      s_axil_awready,

    input  rv_timer_pkg::word_t       s_axil_wdata,
    input  logic [`RVT_XLEN/8-1:0]    s_axil_wstrb,
    input  logic                      s_axil_wvalid,
    output logic                      s_axil_wready,

    output logic [1:0]                s_axil_bresp,
    output logic                      s_axil_bvalid,
    input  logic                      s_axil_bready,

    input  logic [`RVT_AXIL_AW-1:0]   s_axil_araddr,
    input  logic                      s_axil_arvalid,
    output logic                      s_axil_arready,

    output rv_timer_pkg::word_t       s_axil_rdata,
    output logic [1:0]                s_axil_rresp,
    output logic                      s_axil_rvalid,
    input  logic                      s_axil_rready,

    output logic [63:0]               time_value,
    output logic                      irq
);

    import rv_timer_pkg::*;

    // register bus between adapter and timer
    logic                     reg_rd_en;
    logic                     reg_wr_en;
    logic [1:0]               reg_addr;
    word_t                    reg_wr_data;
    logic [`RVT_XLEN/8-1:0]   reg_wr_strb;
    word_t                    reg_rd_data;
    logic                     tick;

    axil_to_regbus u_bus (
        .clk            (clk),
        .rst_n          (rst_n),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .reg_rd_en      (reg_rd_en),
        .reg_wr_en      (reg_wr_en),
        .reg_addr       (reg_addr),
        .reg_wr_data    (reg_wr_data),
        .reg_wr_strb    (reg_wr_strb),
        .reg_rd_data    (reg_rd_data)
    );

    us_prescaler #(
        .CLK_PERIOD_NS (CLK_PERIOD_NS)
    ) u_presc (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    mtimer u_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .rd_en      (reg_rd_en),
        .wr_en      (reg_wr_en),
        .addr       (reg_addr),
        .wr_data    (reg_wr_data),
        .wr_strb    (reg_wr_strb),
        .rd_data    (reg_rd_data),
        .time_value (time_value),
        .irq        (irq)
    );

endmodule

`default_nettype wire

/* test/rv_timer_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_timer_asserts (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       s_axil_awready,
    input logic                       s_axil_wready,
    input logic [1:0]                 s_axil_bresp,
    input logic                       s_axil_bvalid,
    input logic                       s_axil_bready,
    input logic                       s_axil_arready,
    input logic [1:0]                 s_axil_rresp,
    input logic                       s_axil_rvalid,
    input logic                       s_axil_rready,
    input logic [63:0]                time_value,
    input logic                       irq,
    input rv_timer_pkg::timer_reg_u   mtimecmp     // taken from the timer instance
);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    int fail_count = 0;   // failed assertion count

    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
        else begin
            $error("bvalid dropped before bready");
            fail_count++;
        end

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
        else begin
            $error("rvalid dropped before rready");
            fail_count++;
        end

    resp_okay: assert property (@(posedge clk) disable iff (!rst_n)
        (s_axil_bvalid |-> s_axil_bresp == RESP_OKAY) and
        (s_axil_rvalid |-> s_axil_rresp == RESP_OKAY))
        else begin
            $error("response other than OKAY");
            fail_count++;
        end

    // one access at a time
    no_ready_while_pending: assert property (@(posedge clk) disable iff (!rst_n)
        (s_axil_bvalid || s_axil_rvalid) |-> !(s_axil_awready || s_axil_wready || s_axil_arready))
        else begin
            $error("ready raised while a response is pending");
            fail_count++;
        end

    irq_rule: assert property (@(posedge clk) disable iff (!rst_n)
        irq == (time_value >= mtimecmp.full))
        else begin
            $error("irq does not match mtime >= mtimecmp");
            fail_count++;
        end

endmodule

bind rv_timer_top rv_timer_asserts u_asserts (
    .clk            (clk),
    .rst_n          (rst_n),
    .s_axil_awready (s_axil_awready),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_arready (s_axil_arready),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .time_value     (time_value),
    .irq            (irq),
    .mtimecmp       (u_timer.mtimecmp)
);

`default_nettype wire

/* test/rv_timer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_timer_consts.svh"

module rv_timer_tb;

    import rv_timer_pkg::*;

    localparam int CLK_NS       = `RVT_DEFAULT_CLK_PERIOD_NS;
    localparam int CYC_PER_US   = 1000 / CLK_NS;    // clocks per mtime tick
    localparam int N_TESTS      = 6;
    localparam int TEST_BUDGET  = 2000;             // cycles, upper bound for one test
    localparam int SPARE_CYCLES = 8000;             // reset, summary and slack
    localparam longint WATCHDOG_NS = longint'(N_TESTS * TEST_BUDGET + SPARE_CYCLES) * CLK_NS;
    localparam int HS_LIMIT     = 100;              // cycles allowed for one handshake
    localparam int COUNT_WAIT   = 500;
    localparam int CMP_AHEAD    = 20;               // ticks until the compare hits
    localparam int STALL_CYCLES = 20;
    localparam int RAND_ROUNDS  = 32;
    localparam word_t STROBE_WORD = 32'hA1B2_C3D4;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // register byte offsets
    localparam logic [`RVT_AXIL_AW-1:0] A_MTIME_LO    = 4'h0;
    localparam logic [`RVT_AXIL_AW-1:0] A_MTIME_HI    = 4'h4;
    localparam logic [`RVT_AXIL_AW-1:0] A_MTIMECMP_LO = 4'h8;
    localparam logic [`RVT_AXIL_AW-1:0] A_MTIMECMP_HI = 4'hC;

    logic                    clk;
    logic                    rst_n;
    logic [`RVT_AXIL_AW-1:0] s_axil_awaddr;
    logic                    s_axil_awvalid;
    logic                    s_axil_awready;
    word_t                   s_axil_wdata;
    logic [`RVT_XLEN/8-1:0]  s_axil_wstrb;
    logic                    s_axil_wvalid;
    logic                    s_axil_wready;
    logic [1:0]              s_axil_bresp;
    logic                    s_axil_bvalid;
    logic                    s_axil_bready;
    logic [`RVT_AXIL_AW-1:0] s_axil_araddr;
    logic                    s_axil_arvalid;
    logic                    s_axil_arready;
    word_t                   s_axil_rdata;
    logic [1:0]              s_axil_rresp;
    logic                    s_axil_rvalid;
    logic                    s_axil_rready;
    logic [63:0]             time_value;
    logic                    irq;

    logic [31:0] rand_state;
    longint      cycle_cnt;
    int          err_count;
    int          pass_tests;
    int          fail_tests;

    rv_timer_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS/2) clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // 32-bit LCG
    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("[FAIL] t=%0d ns %s expected %h got %h", $time, name, exp, act);
        err_count++;
    endtask

    task automatic log_error(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        err_count++;
    endtask

    task automatic finish_test(input string name, input int errs0);
        int n;
        n = err_count - errs0;
        if (n == 0) begin
            pass_tests++;
            $display("test %s: passed", name);
        end else begin
            fail_tests++;
            $display("test %s: failed with %0d errors", name, n);
        end
    endtask

    // address and data phase, returns with bvalid seen
    task automatic send_write(input logic [`RVT_AXIL_AW-1:0] addr, input word_t data,
                              input logic [3:0] strb);
        int n;
        s_axil_awaddr  = addr;
        s_axil_awvalid = 1'b1;
        s_axil_wdata   = data;
        s_axil_wstrb   = strb;
        s_axil_wvalid  = 1'b1;
        n = 0;
        while (!s_axil_awready && n < HS_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!(s_axil_awready && s_axil_wready))
            log_error("write address and data were not accepted together");
        @(negedge clk);   // handshake edge has passed
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        n = 0;
        while (!s_axil_bvalid && n < HS_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!s_axil_bvalid)
            log_error("no write response from the DUT");
        else if (s_axil_bresp !== RESP_OKAY)
            report_mismatch("s_axil_bresp", RESP_OKAY, s_axil_bresp);
    endtask

    task automatic axil_write(input logic [`RVT_AXIL_AW-1:0] addr, input word_t data,
                              input logic [3:0] strb);
        s_axil_bready = 1'b1;
        send_write(addr, data, strb);
        @(negedge clk);   // response taken, register updated
    endtask

    task automatic axil_read(input logic [`RVT_AXIL_AW-1:0] addr, output word_t data);
        int n;
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        s_axil_rready  = 1'b1;
        n = 0;
        while (!s_axil_arready && n < HS_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!s_axil_arready)
            log_error("read address was not accepted");
        @(negedge clk);
        s_axil_arvalid = 1'b0;
        n = 0;
        while (!s_axil_rvalid && n < HS_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!s_axil_rvalid)
            log_error("no read data from the DUT");
        else if (s_axil_rresp !== RESP_OKAY)
            report_mismatch("s_axil_rresp", RESP_OKAY, s_axil_rresp);
        data = s_axil_rdata;
        @(negedge clk);
    endtask

    task automatic reset_state();
        int    errs0;
        word_t rd;
        errs0 = err_count;
        if (irq !== 1'b1) report_mismatch("irq", 1, irq);
        if ({s_axil_awready, s_axil_wready, s_axil_arready, s_axil_bvalid, s_axil_rvalid} !== 5'b0)
            report_mismatch("ready/valid outputs", 0,
                            {s_axil_awready, s_axil_wready, s_axil_arready,
                             s_axil_bvalid, s_axil_rvalid});
        axil_read(A_MTIMECMP_LO, rd);
        if (rd !== 32'h0) report_mismatch("mtimecmp_lo", 0, rd);
        axil_read(A_MTIMECMP_HI, rd);
        if (rd !== 32'h0) report_mismatch("mtimecmp_hi", 0, rd);
        finish_test("reset_state", errs0);
    endtask

    task automatic count_rate();
        int          errs0;
        word_t       t0;
        word_t       t1;
        word_t       diff;
        word_t       lo_b;
        longint      c0;
        longint      span;
        logic [63:0] tv0;
        logic [63:0] tv_diff;
        errs0 = err_count;
        axil_write(A_MTIME_HI, 32'h0, 4'hF);
        axil_write(A_MTIME_LO, 32'h0, 4'hF);
        axil_read(A_MTIME_LO, t0);
        c0  = cycle_cnt;
        tv0 = time_value;
        repeat (COUNT_WAIT) @(negedge clk);
        axil_read(A_MTIME_LO, t1);
        span = cycle_cnt - c0;   // both reads have the same latency
        diff = t1 - t0;
        lo_b = span / CYC_PER_US;
        if (diff < lo_b || diff > lo_b + 1) begin
            $display("[FAIL] t=%0d ns mtime_lo delta expected %0d..%0d got %0d",
                     $time, lo_b, lo_b + 1, diff);
            err_count++;
        end
        tv_diff = time_value - tv0;   // sampled span cycles apart
        if (tv_diff < lo_b || tv_diff > lo_b + 1) begin
            $display("[FAIL] t=%0d ns time_value delta expected %0d..%0d got %0d",
                     $time, lo_b, lo_b + 1, tv_diff);
            err_count++;
        end
        finish_test("count_rate", errs0);
    endtask

    task automatic irq_compare();
        int    errs0;
        int    n;
        word_t now;
        errs0 = err_count;
        axil_write(A_MTIMECMP_HI, 32'h0, 4'hF);
        axil_read(A_MTIME_LO, now);
        axil_write(A_MTIMECMP_LO, now + CMP_AHEAD, 4'hF);
        if (irq !== 1'b0) report_mismatch("irq", 0, irq);
        n = 0;
        while (!irq && n < (CMP_AHEAD + 1) * CYC_PER_US) begin
            @(negedge clk);
            n++;
        end
        if (!irq)
            log_error("irq did not return after mtime reached mtimecmp");
        else if (n < (CMP_AHEAD - 2) * CYC_PER_US)
            log_error("irq returned before mtime could reach mtimecmp");
        axil_write(A_MTIMECMP_HI, 32'hFFFF_FFFF, 4'hF);
        if (irq !== 1'b0) report_mismatch("irq", 0, irq);
        finish_test("irq_compare", errs0);
    endtask

    // prefill with ones so cleared bytes must come back as zero
    task automatic check_strobed_write(input logic [3:0] strb, input word_t expv);
        word_t rd;
        axil_write(A_MTIMECMP_LO, 32'hFFFF_FFFF, 4'hF);
        axil_write(A_MTIMECMP_LO, STROBE_WORD, strb);
        axil_read(A_MTIMECMP_LO, rd);
        if (rd !== expv) report_mismatch("mtimecmp_lo", expv, rd);
    endtask

    task automatic byte_strobes();
        int errs0;
        errs0 = err_count;
        check_strobed_write(4'b0101, 32'h00B2_00D4);
        check_strobed_write(4'b1010, 32'hA100_C300);
        check_strobed_write(4'b0011, 32'h0000_C3D4);
        finish_test("byte_strobes", errs0);
    endtask

    task automatic backpressure();
        int    errs0;
        word_t val;
        word_t rd;
        errs0 = err_count;
        val = next_rand();
        s_axil_bready = 1'b0;
        send_write(A_MTIMECMP_LO, val, 4'hF);
        s_axil_araddr  = A_MTIMECMP_LO;
        s_axil_arvalid = 1'b1;   // read waits behind the write response
        repeat (STALL_CYCLES) begin
            @(negedge clk);
            if (s_axil_bvalid !== 1'b1) report_mismatch("s_axil_bvalid", 1, s_axil_bvalid);
            if ({s_axil_awready, s_axil_wready, s_axil_arready} !== 3'b000)
                report_mismatch("awready/wready/arready", 0,
                                {s_axil_awready, s_axil_wready, s_axil_arready});
        end
        s_axil_bready = 1'b1;
        @(negedge clk);
        if (s_axil_bvalid !== 1'b0) report_mismatch("s_axil_bvalid", 0, s_axil_bvalid);
        axil_read(A_MTIMECMP_LO, rd);
        if (rd !== val) report_mismatch("mtimecmp_lo", val, rd);
        finish_test("backpressure", errs0);
    endtask

    task automatic random_traffic();
        int    errs0;
        int    half;
        word_t r;
        word_t val;
        word_t rd;
        word_t model [2];   // lo, hi
        errs0    = err_count;
        model[0] = '0;
        model[1] = '0;
        axil_write(A_MTIMECMP_LO, 32'h0, 4'hF);
        axil_write(A_MTIMECMP_HI, 32'h0, 4'hF);
        for (int i = 0; i < RAND_ROUNDS; i++) begin
            r    = next_rand();
            val  = next_rand();
            half = r[16];
            axil_write(half ? A_MTIMECMP_HI : A_MTIMECMP_LO, val, 4'hF);
            model[half] = val;
            axil_read(A_MTIMECMP_LO, rd);
            if (rd !== model[0]) report_mismatch("mtimecmp_lo", model[0], rd);
            axil_read(A_MTIMECMP_HI, rd);
            if (rd !== model[1]) report_mismatch("mtimecmp_hi", model[1], rd);
        end
        finish_test("random_traffic", errs0);
    endtask

    initial begin
        rand_state     = 32'h3838_8b96;
        cycle_cnt      = 0;
        err_count      = 0;
        pass_tests     = 0;
        fail_tests     = 0;
        rst_n          = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b1;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b1;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        reset_state();
        count_rate();
        irq_compare();
        byte_strobes();
        backpressure();
        random_traffic();

        $display("summary: %0d tests passed, %0d tests failed, %0d assertion failures",
                 pass_tests, fail_tests, uut.u_asserts.fail_count);
        if (fail_tests == 0 && err_count == 0 && uut.u_asserts.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+source
source/rv_timer_pkg.sv
source/axil_to_regbus.sv
source/us_prescaler.sv
source/mtimer.sv
source/rv_timer_top.sv
test/rv_timer_asserts.sv
test/rv_timer_tb.sv

/* Bender.yml */
package:
  name: rv_timer

sources:
  - include_dirs:
      - source
    files:
      - source/rv_timer_pkg.sv
      - source/axil_to_regbus.sv
      - source/us_prescaler.sv
      - source/mtimer.sv
      - source/rv_timer_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/rv_timer_asserts.sv
      - test/rv_timer_tb.sv
